// File: logic/exe_alu.sv
module exe_alu (
    input  exe_pkg::alu_fn_t alu_fn,
    input  exe_pkg::word_t   src1,
    input  exe_pkg::word_t   src2,
    output exe_pkg::word_t   result,
    output logic             overflow
);

    logic           subtract;
    exe_pkg::word_t add_b;
    logic [32:0]    add_sum;
    exe_pkg::word_t sum;
    logic           carry_out;
    logic           less_signed;
    logic           less_unsigned;
    logic [4:0]     shamt;

    // one adder for add, sub, compares and addresses
    assign subtract = alu_fn inside {exe_pkg::ALU_SUB, exe_pkg::ALU_SUBU,
                                     exe_pkg::ALU_SLT, exe_pkg::ALU_SLTU};
    assign add_b = subtract ? ~src2 : src2;
    assign add_sum = {1'b0, src1} + {1'b0, add_b} + {32'b0, subtract};
    assign sum = add_sum[31:0];
    assign carry_out = add_sum[32];

    // signed overflow of the adder which the caller masks
    assign overflow = (src1[31] == add_b[31]) && (sum[31] != src1[31]);

    assign less_signed = (src1[31] != src2[31]) ? src1[31] : sum[31];
    // no borrow out means src1 >= src2
    assign less_unsigned = !carry_out;

    assign shamt = src1[4:0];

    always_comb begin
        unique case (alu_fn)
            exe_pkg::ALU_ADD, exe_pkg::ALU_ADDU,
            exe_pkg::ALU_SUB, exe_pkg::ALU_SUBU: result = sum;
            exe_pkg::ALU_SLT: result = {31'b0, less_signed};
            exe_pkg::ALU_SLTU: result = {31'b0, less_unsigned};
            exe_pkg::ALU_AND: result = src1 & src2;
            exe_pkg::ALU_OR: result = src1 | src2;
            exe_pkg::ALU_XOR: result = src1 ^ src2;
            exe_pkg::ALU_NOR: result = ~(src1 | src2);
            exe_pkg::ALU_SLL: result = src2 << shamt;
            exe_pkg::ALU_SRL: result = src2 >> shamt;
            exe_pkg::ALU_SRA: result = $unsigned($signed(src2) >>> shamt);
            exe_pkg::ALU_LUI: result = {src2[15:0], 16'b0};
            default: result = sum;
        endcase
    end

endmodule

// File: logic/exe_decode.sv
module exe_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  exe_pkg::exe_cmd_t   in_cmd,
    output logic                ctrl_valid,
    output exe_pkg::exe_ctrl_t  ctrl
);

    exe_pkg::exe_ctrl_t ctrl_next;

    always_comb begin
        ctrl_next = '0;
        ctrl_next.rs_value = in_cmd.rs_value;
        ctrl_next.rt_value = in_cmd.rt_value;
        ctrl_next.imm = in_cmd.imm;
        ctrl_next.dest = in_cmd.dest;
        ctrl_next.pc = in_cmd.pc;
        ctrl_next.src2_is_imm = (in_cmd.imm_mode != exe_pkg::IMM_NONE);
        ctrl_next.imm_signed = (in_cmd.imm_mode == exe_pkg::IMM_SIGNED);
        // most operations write a register
        ctrl_next.gr_we = 1'b1;
        ctrl_next.alu_fn = exe_pkg::ALU_ADD;

        unique case (in_cmd.op)
            exe_pkg::OP_ADD: ctrl_next.ov_check = 1'b1;
            exe_pkg::OP_ADDU: ctrl_next.alu_fn = exe_pkg::ALU_ADDU;
            exe_pkg::OP_SUB: begin
                ctrl_next.alu_fn = exe_pkg::ALU_SUB;
                ctrl_next.ov_check = 1'b1;
            end
            exe_pkg::OP_SUBU: ctrl_next.alu_fn = exe_pkg::ALU_SUBU;
            exe_pkg::OP_SLT: ctrl_next.alu_fn = exe_pkg::ALU_SLT;
            exe_pkg::OP_SLTU: ctrl_next.alu_fn = exe_pkg::ALU_SLTU;
            exe_pkg::OP_AND: ctrl_next.alu_fn = exe_pkg::ALU_AND;
            exe_pkg::OP_OR: ctrl_next.alu_fn = exe_pkg::ALU_OR;
            exe_pkg::OP_XOR: ctrl_next.alu_fn = exe_pkg::ALU_XOR;
            exe_pkg::OP_NOR: ctrl_next.alu_fn = exe_pkg::ALU_NOR;
            exe_pkg::OP_SLL, exe_pkg::OP_SRL, exe_pkg::OP_SRA: begin
                // shift rt by the sa field
                ctrl_next.alu_fn = (in_cmd.op == exe_pkg::OP_SLL) ? exe_pkg::ALU_SLL :
                                   (in_cmd.op == exe_pkg::OP_SRL) ? exe_pkg::ALU_SRL :
                                                                    exe_pkg::ALU_SRA;
                ctrl_next.src1_is_sa = 1'b1;
                ctrl_next.src2_is_imm = 1'b0;
            end
            exe_pkg::OP_LUI: begin
                ctrl_next.alu_fn = exe_pkg::ALU_LUI;
                ctrl_next.src2_is_imm = 1'b1;
            end
            exe_pkg::OP_MULT, exe_pkg::OP_MULTU: begin
                ctrl_next.mult = 1'b1;
                ctrl_next.mult_signed = (in_cmd.op == exe_pkg::OP_MULT);
                ctrl_next.hi_we = 1'b1;
                ctrl_next.lo_we = 1'b1;
                ctrl_next.gr_we = 1'b0;
            end
            exe_pkg::OP_MFHI: ctrl_next.res_from_hi = 1'b1;
            exe_pkg::OP_MFLO: ctrl_next.res_from_lo = 1'b1;
            exe_pkg::OP_MTHI: begin
                ctrl_next.hi_we = 1'b1;
                ctrl_next.gr_we = 1'b0;
            end
            exe_pkg::OP_MTLO: begin
                ctrl_next.lo_we = 1'b1;
                ctrl_next.gr_we = 1'b0;
            end
            exe_pkg::OP_LB, exe_pkg::OP_LH, exe_pkg::OP_LW,
            exe_pkg::OP_SB, exe_pkg::OP_SH, exe_pkg::OP_SW: begin
                // address is always rs plus the signed offset
                ctrl_next.src2_is_imm = 1'b1;
                ctrl_next.imm_signed = 1'b1;
                ctrl_next.mem_re = in_cmd.op inside {exe_pkg::OP_LB, exe_pkg::OP_LH,
                                                     exe_pkg::OP_LW};
                ctrl_next.mem_we = !ctrl_next.mem_re;
                ctrl_next.gr_we = ctrl_next.mem_re;
                ctrl_next.mem_size =
                    (in_cmd.op inside {exe_pkg::OP_LB, exe_pkg::OP_SB}) ? exe_pkg::SIZE_BYTE :
                    (in_cmd.op inside {exe_pkg::OP_LH, exe_pkg::OP_SH}) ? exe_pkg::SIZE_HALF :
                                                                          exe_pkg::SIZE_WORD;
            end
            default: ctrl_next.gr_we = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            ctrl <= ctrl_next;
        end
    end

endmodule

// File: logic/exe_execute.sv
module exe_execute (
    input  logic               clk,
    input  logic               reset,
    input  logic               ctrl_valid,
    input  exe_pkg::exe_ctrl_t ctrl,
    output logic               mid_valid,
    output exe_pkg::exe_mid_t  mid
);

    exe_pkg::word_t     imm_ext;
    exe_pkg::word_t     src1;
    exe_pkg::word_t     src2;
    exe_pkg::word_t     alu_result;
    logic               alu_overflow;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [63:0] product;
    exe_pkg::word_t     hi;
    exe_pkg::word_t     lo;
    exe_pkg::word_t     hi_next;
    exe_pkg::word_t     lo_next;
    exe_pkg::word_t     result;

    assign imm_ext = ctrl.imm_signed ? {{16{ctrl.imm[15]}}, ctrl.imm} : {16'b0, ctrl.imm};

    assign src1 = ctrl.src1_is_sa ? {27'b0, ctrl.imm[10:6]} : ctrl.rs_value;
    assign src2 = ctrl.src2_is_imm ? imm_ext : ctrl.rt_value;

    exe_alu u_exe_alu (
        .alu_fn   (ctrl.alu_fn),
        .src1     (src1),
        .src2     (src2),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    // one signed 33x33 multiplier covers mult and multu
    assign mul_a = {ctrl.mult_signed & ctrl.rs_value[31], ctrl.rs_value};
    assign mul_b = {ctrl.mult_signed & ctrl.rt_value[31], ctrl.rt_value};
    assign product = mul_a * mul_b;

    assign hi_next = ctrl.mult ? product[63:32] : ctrl.rs_value;
    assign lo_next = ctrl.mult ? product[31:0] : ctrl.rs_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (ctrl_valid) begin
            if (ctrl.hi_we) begin
                hi <= hi_next;
            end
            if (ctrl.lo_we) begin
                lo <= lo_next;
            end
        end
    end

    // mult and mt write no register and give zero
    assign result = ctrl.res_from_hi           ? hi :
                    ctrl.res_from_lo           ? lo :
                    (ctrl.hi_we | ctrl.lo_we)  ? '0 :
                                                 alu_result;

    assign mid_valid = ctrl_valid;

    always_comb begin
        mid.result = result;
        mid.overflow_ex = alu_overflow & ctrl.ov_check;
        mid.rt_value = ctrl.rt_value;
        mid.mem_re = ctrl.mem_re;
        mid.mem_we = ctrl.mem_we;
        mid.mem_size = ctrl.mem_size;
        mid.gr_we = ctrl.gr_we;
        mid.dest = ctrl.dest;
        mid.pc = ctrl.pc;
    end

endmodule

// File: logic/exe_pkg.sv
package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  size_t;
    typedef logic [4:0]  excode_t;

    localparam excode_t EX_ADEL = 5'd4;
    localparam excode_t EX_ADES = 5'd5;
    localparam excode_t EX_OV   = 5'd12;

    // access sizes as seen on the memory request
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    typedef enum logic [4:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA, OP_LUI,
        OP_MULT, OP_MULTU, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_LB, OP_LH, OP_LW, OP_SB, OP_SH, OP_SW
    } exe_op_t;

    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_SIGNED,
        IMM_ZERO
    } imm_mode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_fn_t;

    typedef struct packed {
        exe_op_t   op;
        imm_mode_t imm_mode;
        word_t     rs_value;
        word_t     rt_value;
        imm_t      imm;
        reg_addr_t dest;
        word_t     pc;
    } exe_cmd_t;

    typedef struct packed {
        alu_fn_t   alu_fn;
        logic      src1_is_sa;
        logic      src2_is_imm;
        logic      imm_signed;
        logic      ov_check;
        logic      mult;
        logic      mult_signed;
        logic      hi_we;
        logic      lo_we;
        logic      res_from_hi;
        logic      res_from_lo;
        logic      mem_re;
        logic      mem_we;
        size_t     mem_size;
        logic      gr_we;
        word_t     rs_value;
        word_t     rt_value;
        imm_t      imm;
        reg_addr_t dest;
        word_t     pc;
    } exe_ctrl_t;

    typedef struct packed {
        word_t     result;
        logic      overflow_ex;
        word_t     rt_value;
        logic      mem_re;
        logic      mem_we;
        size_t     mem_size;
        logic      gr_we;
        reg_addr_t dest;
        word_t     pc;
    } exe_mid_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t dest;
        logic      gr_we;
        word_t     result;
        logic      ex;
        excode_t   excode;
        word_t     badvaddr;
    } exe_out_t;

    typedef struct packed {
        logic  we;
        size_t size;
        word_t addr;
        strb_t wstrb;
        word_t wdata;
    } mem_req_t;

endpackage

// File: logic/exe_result.sv
module exe_result (
    input  logic              clk,
    input  logic              reset,
    input  logic              mid_valid,
    input  exe_pkg::exe_mid_t mid,
    output logic              out_valid,
    output exe_pkg::exe_out_t out,
    output logic              mem_valid,
    output exe_pkg::mem_req_t mem_req
);

    logic [1:0]        addr_low;
    logic              misaligned;
    logic              adel;
    logic              ades;
    logic              ex;
    exe_pkg::excode_t  excode;
    exe_pkg::strb_t    wstrb;
    exe_pkg::word_t    wdata;
    exe_pkg::exe_out_t out_next;
    exe_pkg::mem_req_t req_next;

    assign addr_low = mid.result[1:0];

    // halves need bit 0 clear and words both low bits clear
    assign misaligned = ((mid.mem_size == exe_pkg::SIZE_HALF) && addr_low[0]) ||
                        ((mid.mem_size == exe_pkg::SIZE_WORD) && (addr_low != 2'b00));

    assign adel = mid.mem_re & misaligned;
    assign ades = mid.mem_we & misaligned;
    assign ex = mid.overflow_ex | adel | ades;

    // overflow takes priority over the address checks
    assign excode = mid.overflow_ex ? exe_pkg::EX_OV :
                    adel            ? exe_pkg::EX_ADEL :
                    ades            ? exe_pkg::EX_ADES :
                                      '0;

    always_comb begin
        wstrb = '0;
        wdata = '0;
        if (mid.mem_we) begin
            unique case (mid.mem_size)
                exe_pkg::SIZE_BYTE: begin
                    wstrb = 4'b0001 << addr_low;
                    wdata = {4{mid.rt_value[7:0]}};
                end
                exe_pkg::SIZE_HALF: begin
                    wstrb = addr_low[1] ? 4'b1100 : 4'b0011;
                    wdata = {2{mid.rt_value[15:0]}};
                end
                default: begin
                    wstrb = 4'b1111;
                    wdata = mid.rt_value;
                end
            endcase
        end
    end

    always_comb begin
        out_next.pc = mid.pc;
        out_next.dest = mid.dest;
        out_next.gr_we = mid.gr_we & ~ex;
        out_next.result = mid.result;
        out_next.ex = ex;
        out_next.excode = excode;
        out_next.badvaddr = (adel | ades) ? mid.result : '0;

        req_next.we = mid.mem_we;
        req_next.size = mid.mem_size;
        req_next.addr = mid.result;
        req_next.wstrb = wstrb;
        req_next.wdata = wdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            out_valid <= mid_valid;
            // a faulting access never reaches memory
            mem_valid <= mid_valid & (mid.mem_re | mid.mem_we) & ~ex;
        end
    end

    always_ff @(posedge clk) begin
        if (mid_valid) begin
            out <= out_next;
            mem_req <= req_next;
        end
    end

endmodule

// File: logic/exe_stage.sv
module exe_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  exe_pkg::exe_cmd_t in_cmd,
    output logic              out_valid,
    output exe_pkg::exe_out_t out,
    output logic              mem_valid,
    output exe_pkg::mem_req_t mem_req
);

    logic               ctrl_valid;
    exe_pkg::exe_ctrl_t ctrl;
    logic               mid_valid;
    exe_pkg::exe_mid_t  mid;

    // command registered at edge k
    exe_decode u_exe_decode (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_cmd     (in_cmd),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
    );

    // combinational except for HI/LO
    exe_execute u_exe_execute (
        .clk        (clk),
        .reset      (reset),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl),
        .mid_valid  (mid_valid),
        .mid        (mid)
    );

    // result and memory request registered at edge k+1
    exe_result u_exe_result (
        .clk       (clk),
        .reset     (reset),
        .mid_valid (mid_valid),
        .mid       (mid),
        .out_valid (out_valid),
        .out       (out),
        .mem_valid (mem_valid),
        .mem_req   (mem_req)
    );

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_exe_stage -o sim_exe \
    && ./obj_dir/sim_exe | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sources.f
+incdir+tests
logic/exe_pkg.sv
logic/exe_alu.sv
logic/exe_decode.sv
logic/exe_execute.sv
logic/exe_result.sv
logic/exe_stage.sv
tests/tb_exe_stage.sv

// File: tests/exe_tb_tasks.svh
task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] want);
    if (actual !== want) begin
        error_count++;
        $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, want);
    end
endtask

task automatic compare_item(input expect_t e);
    check_value("out_valid cycle", 64'(cycles), 64'(e.due));
    check_value("out.pc", 64'(dut_out.pc), 64'(e.out.pc));
    check_value("out.dest", 64'(dut_out.dest), 64'(e.out.dest));
    check_value("out.gr_we", 64'(dut_out.gr_we), 64'(e.out.gr_we));
    check_value("out.result", 64'(dut_out.result), 64'(e.out.result));
    check_value("out.ex", 64'(dut_out.ex), 64'(e.out.ex));
    check_value("out.excode", 64'(dut_out.excode), 64'(e.out.excode));
    check_value("out.badvaddr", 64'(dut_out.badvaddr), 64'(e.out.badvaddr));
    check_value("mem_valid", 64'(mem_valid), 64'(e.mem_valid));
    if (e.mem_valid && mem_valid) begin
        check_value("mem_req.we", 64'(dut_req.we), 64'(e.req.we));
        check_value("mem_req.size", 64'(dut_req.size), 64'(e.req.size));
        check_value("mem_req.addr", 64'(dut_req.addr), 64'(e.req.addr));
        check_value("mem_req.wstrb", 64'(dut_req.wstrb), 64'(e.req.wstrb));
        check_value("mem_req.wdata", 64'(dut_req.wdata), 64'(e.req.wdata));
    end
endtask

// one command per cycle driven just after the rising edge
task automatic issue(input exe_pkg::exe_op_t op, input exe_pkg::imm_mode_t mode,
                     input exe_pkg::word_t rs, input exe_pkg::word_t rt,
                     input exe_pkg::imm_t imm);
    exe_pkg::exe_cmd_t c;
    expect_t           item;
    c.op = op;
    c.imm_mode = mode;
    c.rs_value = rs;
    c.rt_value = rt;
    c.imm = imm;
    c.dest = 5'($urandom);
    c.pc = $urandom & 32'hffff_fffc;
    @(posedge clk);
    #2;
    in_valid = 1'b1;
    in_cmd = c;
    item = predict(c);
    // strobe comes back after the second edge from here
    item.due = cycles + 2;
    expected.push_back(item);
    issued++;
endtask

task automatic idle();
    @(posedge clk);
    #2;
    in_valid = 1'b0;
endtask

// HI and LO must read zero straight out of reset
task automatic hilo_after_reset();
    issue(exe_pkg::OP_MFLO, exe_pkg::IMM_NONE, 32'h0, 32'h0, 16'h0);
    issue(exe_pkg::OP_MFHI, exe_pkg::IMM_NONE, 32'h0, 32'h0, 16'h0);
    idle();
endtask

task automatic alu_ops();
    int round;
    int i;
    for (round = 0; round < 4; round++) begin
        // ops 0 to 13 of the enum are the ALU functions
        for (i = 0; i < 14; i++) begin
            issue(exe_pkg::exe_op_t'(i), exe_pkg::imm_mode_t'(round % 3),
                  $urandom, $urandom, 16'($urandom));
        end
    end
    idle();
endtask

task automatic overflow_cases();
    exe_pkg::word_t a[4];
    exe_pkg::word_t b[4];
    int             i;
    a = '{32'h7fffffff, 32'h80000000, 32'h80000000, 32'h7fffffff};
    b = '{32'h00000001, 32'h00000001, 32'h80000000, 32'hffffffff};
    for (i = 0; i < 4; i++) begin
        issue(exe_pkg::OP_ADD, exe_pkg::IMM_NONE, a[i], b[i], 16'h0);
        issue(exe_pkg::OP_ADDU, exe_pkg::IMM_NONE, a[i], b[i], 16'h0);
        issue(exe_pkg::OP_SUB, exe_pkg::IMM_NONE, a[i], b[i], 16'h0);
        issue(exe_pkg::OP_SUBU, exe_pkg::IMM_NONE, a[i], b[i], 16'h0);
    end
    idle();
endtask

task automatic mult_and_hilo();
    exe_pkg::word_t a;
    exe_pkg::word_t b;
    int             round;
    for (round = 0; round < 4; round++) begin
        a = $urandom;
        b = $urandom;
        issue(exe_pkg::OP_MULT, exe_pkg::IMM_NONE, a, b, 16'h0);
        issue(exe_pkg::OP_MFHI, exe_pkg::IMM_NONE, 32'h0, 32'h0, 16'h0);
        issue(exe_pkg::OP_MFLO, exe_pkg::IMM_NONE, 32'h0, 32'h0, 16'h0);
        issue(exe_pkg::OP_MULTU, exe_pkg::IMM_NONE, a, b, 16'h0);
        issue(exe_pkg::OP_MFHI, exe_pkg::IMM_NONE, 32'h0, 32'h0, 16'h0);
        issue(exe_pkg::OP_MFLO, exe_pkg::IMM_NONE, 32'h0, 32'h0, 16'h0);
    end
    issue(exe_pkg::OP_MTHI, exe_pkg::IMM_NONE, $urandom, 32'h0, 16'h0);
    issue(exe_pkg::OP_MFHI, exe_pkg::IMM_NONE, 32'h0, 32'h0, 16'h0);
    issue(exe_pkg::OP_MTLO, exe_pkg::IMM_NONE, $urandom, 32'h0, 16'h0);
    issue(exe_pkg::OP_MFLO, exe_pkg::IMM_NONE, 32'h0, 32'h0, 16'h0);
    idle();
endtask

task automatic store_lanes();
    exe_pkg::word_t base;
    int             off;
    base = $urandom & 32'hffff_fff0;
    for (off = 0; off < 4; off++) begin
        issue(exe_pkg::OP_SB, exe_pkg::IMM_SIGNED, base, $urandom, 16'(off));
    end
    for (off = 0; off < 4; off += 2) begin
        issue(exe_pkg::OP_SH, exe_pkg::IMM_SIGNED, base, $urandom, 16'(off));
    end
    issue(exe_pkg::OP_SW, exe_pkg::IMM_SIGNED, base, $urandom, 16'h0008);
    idle();
endtask

// negative offsets also exercise the sign extension
task automatic misaligned_accesses();
    exe_pkg::word_t base;
    int             off;
    base = $urandom & 32'hffff_fff0;
    for (off = 1; off < 4; off++) begin
        issue(exe_pkg::OP_LW, exe_pkg::IMM_SIGNED, base, $urandom, 16'hfff0 | 16'(off));
        issue(exe_pkg::OP_SW, exe_pkg::IMM_SIGNED, base, $urandom, 16'hfff0 | 16'(off));
    end
    for (off = 1; off < 4; off += 2) begin
        issue(exe_pkg::OP_LH, exe_pkg::IMM_SIGNED, base, $urandom, 16'(off));
        issue(exe_pkg::OP_SH, exe_pkg::IMM_SIGNED, base, $urandom, 16'(off));
    end
    for (off = 0; off < 4; off++) begin
        issue(exe_pkg::OP_LB, exe_pkg::IMM_SIGNED, base, $urandom, 16'hfff0 | 16'(off));
    end
    idle();
endtask

// File: tests/tb_exe_stage.sv
module tb_exe_stage;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        exe_pkg::exe_out_t out;
        logic              mem_valid;
        exe_pkg::mem_req_t req;
        int                due;
    } expect_t;

    // commands issued by all directed tests together
    localparam int NUM_CMDS = 2 + 4 * 14 + 4 * 4 + 4 * 6 + 4 + 7 + 14;
    localparam int CYCLE_LIMIT = 2 * NUM_CMDS + 100;

    logic              clk;
    logic              reset;
    logic              in_valid;
    exe_pkg::exe_cmd_t in_cmd;
    logic              out_valid;
    exe_pkg::exe_out_t dut_out;
    logic              mem_valid;
    exe_pkg::mem_req_t dut_req;

    expect_t        expected[$];
    expect_t        seen;
    exe_pkg::word_t model_hi;
    exe_pkg::word_t model_lo;
    int             error_count;
    int             issued;
    int             cycles;

    exe_stage u_exe_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_cmd    (in_cmd),
        .out_valid (out_valid),
        .out       (dut_out),
        .mem_valid (mem_valid),
        .mem_req   (dut_req)
    );

    always #10 clk = ~clk;

    // reference model keeps HI/LO in issue order
    function automatic expect_t predict(input exe_pkg::exe_cmd_t c);
        expect_t            e;
        exe_pkg::word_t     op2;
        exe_pkg::word_t     r;
        logic signed [32:0] wide;
        logic [63:0]        prod;
        logic               load;
        logic               store;
        logic               misaligned;
        int                 i;
        e = '0;
        r = '0;
        op2 = (c.imm_mode == exe_pkg::IMM_NONE)   ? c.rt_value :
              (c.imm_mode == exe_pkg::IMM_SIGNED) ? {{16{c.imm[15]}}, c.imm} : {16'b0, c.imm};
        load = c.op inside {exe_pkg::OP_LB, exe_pkg::OP_LH, exe_pkg::OP_LW};
        store = c.op inside {exe_pkg::OP_SB, exe_pkg::OP_SH, exe_pkg::OP_SW};
        // 33 bits hold any signed sum or difference of two words
        if (c.op == exe_pkg::OP_SUB) begin
            wide = $signed({c.rs_value[31], c.rs_value}) - $signed({op2[31], op2});
        end else begin
            wide = $signed({c.rs_value[31], c.rs_value}) + $signed({op2[31], op2});
        end
        case (c.op)
            exe_pkg::OP_ADD, exe_pkg::OP_ADDU: r = c.rs_value + op2;
            exe_pkg::OP_SUB, exe_pkg::OP_SUBU: r = c.rs_value - op2;
            exe_pkg::OP_SLT: r = {31'b0, $signed(c.rs_value) < $signed(op2)};
            exe_pkg::OP_SLTU: r = {31'b0, c.rs_value < op2};
            exe_pkg::OP_AND: r = c.rs_value & op2;
            exe_pkg::OP_OR: r = c.rs_value | op2;
            exe_pkg::OP_XOR: r = c.rs_value ^ op2;
            exe_pkg::OP_NOR: r = ~(c.rs_value | op2);
            exe_pkg::OP_SLL: r = c.rt_value << c.imm[10:6];
            exe_pkg::OP_SRL: r = c.rt_value >> c.imm[10:6];
            exe_pkg::OP_SRA: r = $signed(c.rt_value) >>> c.imm[10:6];
            exe_pkg::OP_LUI: r = {c.imm, 16'b0};
            exe_pkg::OP_MULT: begin
                prod = {{32{c.rs_value[31]}}, c.rs_value} * {{32{c.rt_value[31]}}, c.rt_value};
                {model_hi, model_lo} = prod;
            end
            exe_pkg::OP_MULTU: begin
                prod = {32'b0, c.rs_value} * {32'b0, c.rt_value};
                {model_hi, model_lo} = prod;
            end
            exe_pkg::OP_MFHI: r = model_hi;
            exe_pkg::OP_MFLO: r = model_lo;
            exe_pkg::OP_MTHI: model_hi = c.rs_value;
            exe_pkg::OP_MTLO: model_lo = c.rs_value;
            // loads and stores give the address
            default: r = c.rs_value + {{16{c.imm[15]}}, c.imm};
        endcase
        misaligned = (c.op inside {exe_pkg::OP_LW, exe_pkg::OP_SW} && r[1:0] != 2'b00) ||
                     (c.op inside {exe_pkg::OP_LH, exe_pkg::OP_SH} && r[0]);
        e.out.pc = c.pc;
        e.out.dest = c.dest;
        e.out.result = r;
        e.out.gr_we = !store && !(c.op inside {exe_pkg::OP_MULT, exe_pkg::OP_MULTU,
                                               exe_pkg::OP_MTHI, exe_pkg::OP_MTLO});
        if (c.op inside {exe_pkg::OP_ADD, exe_pkg::OP_SUB} && wide[32] != wide[31]) begin
            e.out.ex = 1'b1;
            e.out.excode = exe_pkg::EX_OV;
        end else if (misaligned) begin
            e.out.ex = 1'b1;
            e.out.excode = load ? exe_pkg::EX_ADEL : exe_pkg::EX_ADES;
            e.out.badvaddr = r;
        end
        if (e.out.ex) begin
            e.out.gr_we = 1'b0;
        end
        e.mem_valid = (load || store) && !e.out.ex;
        e.req.we = store;
        e.req.addr = r;
        e.req.size = (c.op inside {exe_pkg::OP_LB, exe_pkg::OP_SB}) ? 2'd0 :
                     (c.op inside {exe_pkg::OP_LH, exe_pkg::OP_SH}) ? 2'd1 : 2'd2;
        if (store) begin
            // lanes from the address byte up to the access size
            for (i = 0; i < 4; i++) begin
                e.req.wstrb[i] = (i >= int'(r[1:0])) && (i < int'(r[1:0]) + (1 << e.req.size));
            end
            e.req.wdata = (e.req.size == 2'd0) ? {4{c.rt_value[7:0]}} :
                          (e.req.size == 2'd1) ? {2{c.rt_value[15:0]}} : c.rt_value;
        end
        return e;
    endfunction

    `include "exe_tb_tasks.svh"

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // outputs are sampled half a cycle after they change
    always @(negedge clk) begin
        if (reset) begin
            if (out_valid !== 1'b0 || mem_valid !== 1'b0) begin
                error_count++;
                $display("output strobe was not low during reset at %0t ns", $time);
            end
        end else if (out_valid) begin
            if (expected.size() == 0) begin
                error_count++;
                $display("result strobe at %0t ns with no command outstanding", $time);
            end else begin
                seen = expected.pop_front();
                compare_item(seen);
            end
        end else if (mem_valid) begin
            error_count++;
            $display("memory request at %0t ns without a result strobe", $time);
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_cmd = '0;
        model_hi = '0;
        model_lo = '0;
        error_count = 0;
        issued = 0;
        cycles = 0;
        void'($urandom(32'h9449c2fe));
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        hilo_after_reset();
        alu_ops();
        overflow_cases();
        mult_and_hilo();
        store_lanes();
        misaligned_accesses();
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        // catch any extra strobe
        repeat (3) @(negedge clk);
        $display("%0d commands issued, %0d errors", issued, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
